/* bench/hpf_properties.sv */
`timescale 1ns/10ps
`default_nettype none

module hpf_properties (
	input wire        i_CLK,
	input wire        i_RSTN,
	input wire        o_x_ready,
	input wire [31:0] o_y_data,
	input wire        o_y_valid,
	input wire        i_y_ack
);
	// ============================================================
	// output handshake rules
	// ============================================================
	y_data_held: assert property (@(posedge i_CLK) disable iff (!i_RSTN)
		(o_y_valid && !i_y_ack) |=> $stable(o_y_data))
		else $error("o_y_data changed while waiting for i_y_ack");

	// one sample in flight at the top level
	valid_held_no_ready: assert property (@(posedge i_CLK) disable iff (!i_RSTN)
		(o_y_valid && !i_y_ack) |=> (o_y_valid && !o_x_ready))
		else $error("o_y_valid dropped or o_x_ready rose before i_y_ack");

	no_valid_after_reset: assert property (@(posedge i_CLK)
		$rose(i_RSTN) |-> !o_y_valid)
		else $error("o_y_valid high right after reset");
endmodule

bind hpf_top hpf_properties hpf_properties_i (
	.i_CLK     (i_CLK),
	.i_RSTN    (i_RSTN),
	.o_x_ready (o_x_ready),
	.o_y_data  (o_y_data),
	.o_y_valid (o_y_valid),
	.i_y_ack   (i_y_ack)
);

`default_nettype wire

/* bench/hpf_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "hpf_macros.svh"

module hpf_tb;
	localparam int N_SAMPLES = 4 + 9 + 200;          // zero, impulse, random
	localparam int TIMEOUT   = N_SAMPLES * 30 + 200; // cycles

	logic        i_CLK = 1'b0;
	logic        i_RSTN;
	logic [31:0] i_x_data;
	logic        i_x_valid;
	logic        o_x_ready;
	logic [31:0] o_y_data;
	logic        o_y_valid;
	logic        i_y_ack;

	logic [31:0] exp_q[$];        // expected outputs, oldest first
	logic [31:0] expected;
	string       cur_test;
	int          check_count = 0;
	int          err_count   = 0;
	int          cycles      = 0;
	logic [31:0] m_x_cur  = '0;   // model history, zero like the DUT after reset
	logic [31:0] m_x_prev = '0;
	logic [31:0] m_y_last = '0;

	hpf_top hpf_top_i (.*);

	always #10 i_CLK = ~i_CLK; // 20 ns period

	// ============================================================
	// reference model
	// ============================================================
	function automatic logic [31:0] ref_add(input logic [31:0] a, input logic [31:0] b);
		logic [31:0] hi, lo;
		logic [24:0] s_hi, s_lo, s; // one carry bit above the significand
		int          e;
		if (a[30:0] >= b[30:0]) begin // larger magnitude first
			hi = a;
			lo = b;
		end else begin
			hi = b;
			lo = a;
		end
		s_hi = (hi[30:23] == 0) ? 25'd0 : {2'b01, hi[22:0]};
		s_lo = (lo[30:23] == 0) ? 25'd0 : {2'b01, lo[22:0]};
		s_lo = s_lo >> (int'(hi[30:23]) - int'(lo[30:23])); // truncating align
		s    = (hi[31] != lo[31]) ? s_hi - s_lo : s_hi + s_lo;
		if (s == 0)
			return 32'h0;
		e = int'(hi[30:23]);
		while (s[24]) begin // carry, drop lsb
			s = s >> 1;
			e++;
		end
		while (!s[23]) begin
			s = s << 1;
			e--;
		end
		if (e <= 0)
			return 32'h0; // flush
		return {hi[31], e[7:0], s[22:0]};
	endfunction

	function automatic logic [31:0] ref_mul(input logic [31:0] a, input logic [31:0] b);
		logic [47:0] prod;
		logic [22:0] man;
		int          e;
		if (a[30:23] == 0 || b[30:23] == 0)
			return 32'h0;
		prod = {24'd0, 1'b1, a[22:0]} * {24'd0, 1'b1, b[22:0]};
		e    = int'(a[30:23]) + int'(b[30:23]) - 127;
		if (prod[47]) begin
			e++;
			man = prod[46:24];
		end else begin
			man = prod[45:23];
		end
		if (e <= 0)
			return 32'h0;
		return {a[31] ^ b[31], e[7:0], man};
	endfunction

	// three steps in sequencer order, updates model history
	function automatic logic [31:0] ref_hpf(input logic [31:0] x);
		logic [31:0] d, p, q, y;
		m_x_prev = m_x_cur;
		m_x_cur  = x;
		d        = ref_add(m_x_cur, {~m_x_prev[31], m_x_prev[30:0]});
		p        = ref_mul(`HPF_OMEGA, m_y_last);
		q        = ref_mul(`HPF_OMEGA, d);
		y        = ref_add(q, p);
		m_y_last = y;
		return y;
	endfunction

	// ============================================================
	// checker and timeout
	// ============================================================
	always @(posedge i_CLK) begin
		if (i_RSTN && o_y_valid && i_y_ack) begin // output handshake
			if (exp_q.size() == 0) begin
				$display("%s: output handshake with no sample pending", cur_test);
				err_count++;
			end else begin
				expected = exp_q.pop_front();
				check_count++;
				if (o_y_data !== expected) begin
					$display("Fail %s: expected %h, actual %h", cur_test, expected, o_y_data);
					err_count++;
				end
			end
		end
	end

	always @(posedge i_CLK) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT) begin
			$display("timeout after %0d cycles, DUT stopped answering", cycles);
			$display("Testbench failed");
			$finish;
		end
	end

	// ============================================================
	// stimulus
	// ============================================================
	// one sample in, one result out, ack after ack_delay cycles
	task automatic process_sample(input logic [31:0] x, input int ack_delay);
		exp_q.push_back(ref_hpf(x));
		@(posedge i_CLK);
		while (!o_x_ready) @(posedge i_CLK);
		#2;
		i_x_data  = x;
		i_x_valid = 1'b1;
		@(posedge i_CLK); // taken here
		#2;
		i_x_valid = 1'b0;
		@(posedge i_CLK);
		while (!o_y_valid) @(posedge i_CLK);
		repeat (ack_delay) begin
			if (o_x_ready) begin
				$display("%s: o_x_ready high while result waits for ack", cur_test);
				err_count++;
			end
			@(posedge i_CLK);
		end
		#2;
		i_y_ack = 1'b1;
		@(posedge i_CLK);
		#2;
		i_y_ack = 1'b0;
	endtask

	task automatic report_test(input int checks0, input int errs0);
		$display("test %s: %0d checks, %0d errors", cur_test,
		         check_count - checks0, err_count - errs0);
	endtask

	initial begin
		int          c0, e0;
		logic [31:0] x;
		i_RSTN    = 1'b0;
		i_x_data  = '0;
		i_x_valid = 1'b0;
		i_y_ack   = 1'b0;
		cur_test  = "reset";
		void'($urandom(48829));
		repeat (16) @(posedge i_CLK);
		#2;
		i_RSTN = 1'b1;

		c0 = check_count;
		e0 = err_count;
		@(posedge i_CLK);
		if (!o_x_ready || o_y_valid) begin
			$display("reset: o_x_ready not high or o_y_valid not low after reset");
			err_count++;
		end
		report_test(c0, e0);

		cur_test = "zero_input"; // history is still zero from reset
		c0 = check_count;
		e0 = err_count;
		repeat (4) begin
			process_sample(32'h0, 0);
			check_count++;
			if (o_y_data !== 32'h0) begin // +0 exactly, no negative zero
				$display("Fail %s: expected %h, actual %h", cur_test, 32'h0, o_y_data);
				err_count++;
			end
		end
		report_test(c0, e0);

		cur_test = "impulse";
		c0 = check_count;
		e0 = err_count;
		process_sample(32'h3f800000, 0); // 1.0
		repeat (8) process_sample(32'h0, 0);
		report_test(c0, e0);

		cur_test = "random_backpressure";
		c0 = check_count;
		e0 = err_count;
		repeat (200) begin
			x[31]    = $urandom_range(1, 0);
			x[30:23] = 8'(100 + $urandom_range(50, 0)); // exponent 100..150
			x[22:0]  = 23'($urandom);
			process_sample(x, $urandom_range(8, 0));
		end
		report_test(c0, e0);

		$display("checks passed %0d, failed %0d", check_count - err_count, err_count);
		if (err_count == 0 && exp_q.size() == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end
endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# build and run the hpf testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module hpf_tb -f tb.f --Mdir obj_dir -o hpf_sim \
	&& ./obj_dir/hpf_sim | tee /dev/stderr | grep -qx "Testbench passed" \
	&& exit 0 \
	|| exit 1

/* tb.f */
+incdir+verilog
verilog/hpf_pkg.sv
verilog/fp_op_if.sv
verilog/fp_adder.sv
verilog/fp_multiplier.sv
verilog/hpf_sequencer.sv
verilog/hpf_top.sv
bench/hpf_properties.sv
bench/hpf_tb.sv

/* verilog/fp_adder.sv */
`timescale 1ns/10ps
`default_nettype none

`include "hpf_macros.svh"

module fp_adder import hpf_pkg::*; (
	input wire    i_CLK,
	input wire    i_RSTN,
	fp_op_if.unit op
);
	localparam int SIG_W = `FP_MAN_W + 1; // significand with hidden one

	// leading zeros of a significand, SIG_W when all zero
	function automatic logic [4:0] lzc(input logic [SIG_W-1:0] v);
		logic [4:0] n;
		n = 5'(SIG_W);
		for (int i = 0; i < SIG_W; i++)
			if (v[i]) n = 5'(SIG_W - 1 - i); // highest set bit wins
		return n;
	endfunction

	logic [`FP_ADD_LAT-1:0] vld; // one valid per stage, last one is z_stb
	logic                   accept;

	// ============================================================
	// stage 1  order by magnitude and align
	// ============================================================
	fp_word_u             w_a, w_b, w_big, w_small;
	logic                 a_ge_b;
	logic [`FP_EXP_W-1:0] exp_diff;
	logic [SIG_W-1:0]     big_sig, small_sig;

	always_comb begin
		w_a.raw   = op.a;
		w_b.raw   = op.b;
		a_ge_b    = {w_a.f.exp, w_a.f.man} >= {w_b.f.exp, w_b.f.man}; // exponent first
		w_big     = a_ge_b ? w_a : w_b;
		w_small   = a_ge_b ? w_b : w_a;
		exp_diff  = w_big.f.exp - w_small.f.exp;
		big_sig   = (w_big.f.exp == '0) ? '0 : {1'b1, w_big.f.man};
		small_sig = (w_small.f.exp == '0) ? '0 : {1'b1, w_small.f.man};
	end

	logic                 s1_sign, s1_sub;
	logic [`FP_EXP_W-1:0] s1_exp;
	logic [SIG_W-1:0]     s1_big, s1_small;

	// ============================================================
	// stage 2  add or subtract, stage 3  normalize
	// ============================================================
	logic                 s2_sign;
	logic [`FP_EXP_W-1:0] s2_exp;
	logic [SIG_W:0]       s2_sum;  // one carry bit on top

	logic [4:0]               lz;
	logic [SIG_W-1:0]         norm_sig;
	logic signed [`FP_EXP_W+1:0] res_exp; // room for underflow below 0
	logic [`FP_MAN_W-1:0]     res_man;
	fp_word_u                 res;
	logic [`FP_W-1:0]         r_z;

	always_comb begin
		lz       = lzc(s2_sum[SIG_W-1:0]);
		norm_sig = s2_sum[SIG_W-1:0] << lz;
		if (s2_sum[SIG_W]) begin // carry out, shift right one and drop the lsb
			res_exp = {2'b00, s2_exp} + 10'd1;
			res_man = s2_sum[SIG_W-1:1];
		end else begin
			res_exp = {2'b00, s2_exp} - {5'd0, lz};
			res_man = norm_sig[`FP_MAN_W-1:0];
		end
		if (s2_sum == '0 || res_exp <= 0) begin
			res.raw = '0; // exact zero and underflow give +0
		end else begin
			res.f.sign = s2_sign;
			res.f.exp  = res_exp[`FP_EXP_W-1:0];
			res.f.man  = res_man;
		end
	end

	// ============================================================
	// handshake
	// ============================================================
	assign op.ab_ack = ~|vld; // empty unit only
	assign accept    = op.ab_stb & op.ab_ack;
	assign op.z_stb  = vld[`FP_ADD_LAT-1];
	assign op.z      = r_z;

	always_ff @(posedge i_CLK or negedge i_RSTN) begin
		if (!i_RSTN) begin
			vld <= '0;
		end else begin
			vld[0] <= accept;
			vld[1] <= vld[0];
			vld[`FP_ADD_LAT-1] <= vld[1] | (op.z_stb & ~op.z_ack); // hold until ack
		end
	end

	always_ff @(posedge i_CLK) begin
		if (accept) begin
			s1_sign  <= w_big.f.sign;
			s1_sub   <= w_big.f.sign ^ w_small.f.sign;
			s1_exp   <= w_big.f.exp;
			s1_big   <= big_sig;
			s1_small <= small_sig >> exp_diff; // shifted-out bits are lost
		end
		if (vld[0]) begin
			s2_sign <= s1_sign;
			s2_exp  <= s1_exp;
			s2_sum  <= s1_sub ? {1'b0, s1_big} - {1'b0, s1_small}
			                  : {1'b0, s1_big} + {1'b0, s1_small};
		end
		if (vld[1])
			r_z <= res.raw;
	end
endmodule

`default_nettype wire

/* verilog/fp_multiplier.sv */
`timescale 1ns/10ps
`default_nettype none

`include "hpf_macros.svh"

module fp_multiplier import hpf_pkg::*; (
	input wire    i_CLK,
	input wire    i_RSTN,
	fp_op_if.unit op
);
	localparam int SIG_W = `FP_MAN_W + 1;

	logic [`FP_MUL_LAT-1:0] vld; // stage valids, top bit is z_stb
	logic                   accept;
	fp_word_u               w_a, w_b, res;

	// ============================================================
	// stage 1  significand product and raw exponent
	// ============================================================
	logic                        s1_sign, s1_zero;
	logic signed [`FP_EXP_W+1:0] s1_exp;
	logic [2*SIG_W-1:0]          s1_prod;

	always_comb begin
		w_a.raw = op.a;
		w_b.raw = op.b;
	end

	// ============================================================
	// stage 2  normalize by at most one place
	// ============================================================
	logic signed [`FP_EXP_W+1:0] res_exp;
	logic [`FP_MAN_W-1:0]        res_man;
	logic [`FP_W-1:0]            r_z;

	always_comb begin
		if (s1_prod[2*SIG_W-1]) begin // product in [2,4)
			res_exp = s1_exp + 10'sd1;
			res_man = s1_prod[2*SIG_W-2 -: `FP_MAN_W];
		end else begin
			res_exp = s1_exp;
			res_man = s1_prod[2*SIG_W-3 -: `FP_MAN_W]; // lower bits truncated
		end
		if (s1_zero || res_exp <= 0) begin
			res.raw = '0;
		end else begin
			res.f.sign = s1_sign;
			res.f.exp  = res_exp[`FP_EXP_W-1:0];
			res.f.man  = res_man;
		end
	end

	assign op.ab_ack = ~|vld;
	assign accept    = op.ab_stb & op.ab_ack;
	assign op.z_stb  = vld[`FP_MUL_LAT-1];
	assign op.z      = r_z;

	always_ff @(posedge i_CLK or negedge i_RSTN) begin
		if (!i_RSTN) begin
			vld <= '0;
		end else begin
			vld[0] <= accept;
			vld[`FP_MUL_LAT-1] <= vld[0] | (op.z_stb & ~op.z_ack);
		end
	end

	always_ff @(posedge i_CLK) begin
		if (accept) begin
			s1_sign <= w_a.f.sign ^ w_b.f.sign;
			s1_zero <= (w_a.f.exp == '0) || (w_b.f.exp == '0); // zero operand
			s1_exp  <= {2'b00, w_a.f.exp} + {2'b00, w_b.f.exp} - 10'(`FP_BIAS);
			s1_prod <= {1'b1, w_a.f.man} * {1'b1, w_b.f.man};
		end
		if (vld[0])
			r_z <= res.raw;
	end
endmodule

`default_nettype wire

/* verilog/fp_op_if.sv */
`timescale 1ns/10ps
`default_nettype none

`include "hpf_macros.svh"

interface fp_op_if;
	logic [`FP_W-1:0] a;      // operand a
	logic [`FP_W-1:0] b;      // operand b
	logic             ab_stb; // operands valid
	logic             ab_ack; // unit empty, can take operands
	logic [`FP_W-1:0] z;      // result
	logic             z_stb;  // result valid, held until z_ack
	logic             z_ack;  // result taken

	modport issuer (output a, b, ab_stb, z_ack, input ab_ack, z, z_stb);
	modport unit   (input a, b, ab_stb, z_ack, output ab_ack, z, z_stb);
endinterface

`default_nettype wire

/* verilog/hpf_macros.svh */
`ifndef HPF_MACROS_SVH
`define HPF_MACROS_SVH

// ============================================================
// single precision float layout
// ============================================================
`define FP_W      32 // whole word
`define FP_EXP_W  8  // exponent field
`define FP_MAN_W  23 // stored mantissa, hidden one not included
`define FP_BIAS   127

// ============================================================
// filter coefficient
// ============================================================
// omega ~ 0.8883648, 5 Hz cut-off at 250 Hz sampling
`define HPF_OMEGA 32'h3f636be3

// ============================================================
// unit latencies, acceptance to result strobe
// ============================================================
`define FP_ADD_LAT 3 // align / add / normalize
`define FP_MUL_LAT 2 // multiply / normalize

`endif

/* verilog/hpf_pkg.sv */
`default_nettype none

`include "hpf_macros.svh"

package hpf_pkg;

	// ============================================================
	// float word views
	// ============================================================
	typedef struct packed {
		logic                 sign; // 1 = negative
		logic [`FP_EXP_W-1:0] exp;  // biased, 0 taken as zero
		logic [`FP_MAN_W-1:0] man;  // fraction without hidden one
	} fp_fields_t;

	// same 32 bits, raw on the ports, fields inside the units
	typedef union packed {
		logic [`FP_W-1:0] raw;
		fp_fields_t       f;
	} fp_word_u;

	// ============================================================
	// sequencer FSM
	// ============================================================
	typedef enum logic [1:0] {
		IDLE  = 2'd0, // waiting for a sample
		ISSUE = 2'd1, // strobing operands of the current step
		WAIT  = 2'd2, // waiting for result strobes
		DONE  = 2'd3  // output valid, waiting for ack
	} seq_state_e;

endpackage

`default_nettype wire

/* verilog/hpf_sequencer.sv */
`timescale 1ns/10ps
`default_nettype none

`include "hpf_macros.svh"

module hpf_sequencer import hpf_pkg::*; (
	input  wire              i_CLK,
	input  wire              i_RSTN,
	input  wire  [`FP_W-1:0] i_x_data,  // sample x[n]
	input  wire              i_x_valid,
	output logic             o_x_ready, // high in IDLE only
	output logic [`FP_W-1:0] o_y_data,  // filter output y[n]
	output logic             o_y_valid, // held until i_y_ack
	input  wire              i_y_ack,
	fp_op_if.issuer          add,
	fp_op_if.issuer          mul
);
	// y[n] = omega*y[n-1] + omega*(x[n] - x[n-1])
	//   step 0  d = x[n] + (-x[n-1])   p = omega*y[n-1]
	//   step 1  q = omega*d
	//   step 2  y = q + p

	seq_state_e r_state;
	logic [1:0] r_step;

	// ============================================================
	// history and intermediates
	// ============================================================
	logic [`FP_W-1:0] r_x_cur;  // x[n]
	logic [`FP_W-1:0] r_x_prev; // x[n-1]
	logic [`FP_W-1:0] r_y_prev; // y[n-1]
	logic [`FP_W-1:0] r_d;      // x[n] - x[n-1]
	logic [`FP_W-1:0] r_p;      // omega*y[n-1]
	logic [`FP_W-1:0] r_q;      // omega*d

	logic use_add;  // adder busy in this step
	logic use_mul;  // multiplier busy in this step
	logic w_issue;  // all needed units take operands this cycle
	logic w_retire; // all needed results present this cycle

	assign use_add = (r_step != 2'd1);
	assign use_mul = (r_step != 2'd2);

	assign w_issue  = (r_state == ISSUE)
	                  && (!use_add || add.ab_ack) && (!use_mul || mul.ab_ack);
	assign w_retire = (r_state == WAIT)
	                  && (!use_add || add.z_stb) && (!use_mul || mul.z_stb);

	// strobes go out together so step 0 starts both units on one edge
	assign add.ab_stb = w_issue & use_add;
	assign mul.ab_stb = w_issue & use_mul;
	assign add.z_ack  = w_retire & use_add;
	assign mul.z_ack  = w_retire & use_mul;

	// ============================================================
	// operand select
	// ============================================================
	assign add.a = (r_step == 2'd2) ? r_q : r_x_cur;
	assign add.b = (r_step == 2'd2) ? r_p
	                                : {~r_x_prev[`FP_W-1], r_x_prev[`FP_W-2:0]}; // -x[n-1]
	assign mul.a = `HPF_OMEGA; // every product uses omega
	assign mul.b = (r_step == 2'd1) ? r_d : r_y_prev;

	assign o_x_ready = (r_state == IDLE);
	assign o_y_valid = (r_state == DONE);

	// ============================================================
	// FSM and history
	// ============================================================
	always_ff @(posedge i_CLK or negedge i_RSTN) begin
		if (!i_RSTN) begin
			r_state  <= IDLE;
			r_step   <= 2'd0;
			r_x_cur  <= '0; // history starts at zero
			r_x_prev <= '0;
			r_y_prev <= '0;
			o_y_data <= '0;
		end else begin
			case (r_state)
				IDLE: begin
					if (i_x_valid && o_x_ready) begin
						r_x_prev <= r_x_cur;  // shift on the taking edge
						r_x_cur  <= i_x_data;
						r_y_prev <= o_y_data; // last output
						r_step   <= 2'd0;
						r_state  <= ISSUE;
					end
				end
				ISSUE: begin
					if (w_issue)
						r_state <= WAIT;
				end
				WAIT: begin
					if (w_retire) begin
						if (r_step == 2'd2) begin
							o_y_data <= add.z; // q + p
							r_step   <= 2'd0;
							r_state  <= DONE;
						end else begin
							r_step  <= r_step + 2'd1;
							r_state <= ISSUE;
						end
					end
				end
				DONE: begin
					if (i_y_ack)
						r_state <= IDLE; // ready again the cycle after ack
				end
				default: r_state <= IDLE;
			endcase
		end
	end

	// intermediate results, captured on the acking cycle
	always_ff @(posedge i_CLK) begin
		if (w_retire && r_step == 2'd0) begin
			r_d <= add.z;
			r_p <= mul.z;
		end
		if (w_retire && r_step == 2'd1)
			r_q <= mul.z;
	end
endmodule

`default_nettype wire

/* verilog/hpf_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "hpf_macros.svh"

module hpf_top (
	input  wire              i_CLK,
	input  wire              i_RSTN,     // async, active low
	input  wire  [`FP_W-1:0] i_x_data,   // float sample in
	input  wire              i_x_valid,
	output logic             o_x_ready,
	output logic [`FP_W-1:0] o_y_data,   // float result out
	output logic             o_y_valid,
	input  wire              i_y_ack
);
	// ============================================================
	// one shared adder, one shared multiplier
	// ============================================================
	fp_op_if add_if ();
	fp_op_if mul_if ();

	hpf_sequencer u_sequencer (
		.i_CLK     (i_CLK),
		.i_RSTN    (i_RSTN),
		.i_x_data  (i_x_data),
		.i_x_valid (i_x_valid),
		.o_x_ready (o_x_ready),
		.o_y_data  (o_y_data),
		.o_y_valid (o_y_valid),
		.i_y_ack   (i_y_ack),
		.add       (add_if.issuer),
		.mul       (mul_if.issuer)
	);

	fp_adder u_adder (
		.i_CLK  (i_CLK),
		.i_RSTN (i_RSTN),
		.op     (add_if.unit)
	);

	fp_multiplier u_multiplier (
		.i_CLK  (i_CLK),
		.i_RSTN (i_RSTN),
		.op     (mul_if.unit)
	);
endmodule

`default_nettype wire
